// ==== design/bidir_consts.svh ====
/*
 * Build-time sizes for the bidirectional vector queue
 * BIDIR_FIFO_DEPTH must be at least 2
 */
`ifndef BIDIR_CONSTS_SVH
`define BIDIR_CONSTS_SVH

// Bits in one lane word
`define BIDIR_LANE_BW 8

// Lanes per vector, lane 0 is packed at the MSB end
`define BIDIR_VSIZE 4

// Default number of tagged vectors held by the shared FIFO
`define BIDIR_FIFO_DEPTH 4

`endif

// ==== design/bidir_pkg.sv ====
/*
 * Types shared by the bidirectional vector queue and its testbench
 * Widths come from bidir_consts.svh
 * Direction 0 is forward (dst0), direction 1 is backward (dst1)
 */
`include "bidir_consts.svh"

package bidir_pkg;

	// ==================================================
	// Payload
	// ==================================================

	// One lane word
	typedef logic [`BIDIR_LANE_BW-1:0] lane_t;

	// Ascending range keeps lane 0 of the vector in the top bits
	typedef lane_t [0:`BIDIR_VSIZE-1] vec_t;

	// ==================================================
	// Direction tag
	// ==================================================
	typedef logic [0:0] dir_t;

	localparam dir_t DIR_FWD = 1'b0;
	localparam dir_t DIR_BWD = 1'b1;

	// FIFO entry with the tag above the payload
	typedef struct packed {
		dir_t dir;
		vec_t data;
	} tagged_vec_t;

endpackage

// ==== design/rdyack_fifo.sv ====
/*
 * Circular-buffer FIFO of tagged vectors with rdy/ack on both sides
 * DEPTH must be at least 2, any value, not only powers of two
 * in_ack and out_data are combinational, no fall-through from in to out
 * A write is taken while full when the head leaves in the same cycle
 */
`timescale 1ns/1ps
`include "bidir_consts.svh"

module rdyack_fifo
	import bidir_pkg::*;
#(
	parameter int DEPTH = `BIDIR_FIFO_DEPTH
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_rdy,
	output logic        in_ack,
	input  tagged_vec_t in_data,
	output logic        out_rdy,
	input  logic        out_ack,
	output tagged_vec_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// ==================================================
	// Storage and pointers
	// ==================================================

	// One tagged vector per entry
	tagged_vec_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	// ==================================================
	// Handshake
	// ==================================================
	always_comb begin
		full  = (count == CNT_W'(DEPTH));
		empty = (count == '0);
		// Head is visible as soon as one entry exists
		out_rdy  = !empty;
		out_data = mem[rd_ptr];
		// Full buffer still accepts when the head drains this cycle
		in_ack = in_rdy && (!full || out_ack);
		do_wr  = in_ack;
		do_rd  = out_rdy && out_ack;
	end

	// ==================================================
	// State update
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				// Wrap explicitly so DEPTH need not be a power of two
				if (wr_ptr == PTR_W'(DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_rd) begin
				if (rd_ptr == PTR_W'(DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// Simultaneous read and write leaves the count unchanged
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	// Payload write
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

// ==== design/src_rr_arbiter.sv ====
/*
 * Two-way round-robin source arbiter, combinational grant
 * At most one request is passed downstream in any cycle
 * After reset forward wins the first contested cycle
 */
`timescale 1ns/1ps

module src_rr_arbiter
	import bidir_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic req0_rdy,
	output logic req0_ack,
	input  logic req1_rdy,
	output logic req1_ack,
	output logic grant_rdy,
	output dir_t grant_dir,
	input  logic grant_ack
);

	// Direction of the last completed transfer
	dir_t last_dir;

	// ==================================================
	// Grant selection
	// ==================================================
	always_comb begin
		grant_rdy = req0_rdy || req1_rdy;
		if (req0_rdy && req1_rdy) begin
			// A contested cycle serves the side not served last
			grant_dir = (last_dir == DIR_FWD) ? DIR_BWD : DIR_FWD;
		end else if (req1_rdy) begin
			grant_dir = DIR_BWD;
		end else begin
			// Forward is also the idle value while grant_rdy is low
			grant_dir = DIR_FWD;
		end
		// Only the granted side sees the downstream ack
		req0_ack = grant_ack && req0_rdy && (grant_dir == DIR_FWD);
		req1_ack = grant_ack && req1_rdy && (grant_dir == DIR_BWD);
	end

	// Pointer moves only on an accepted transfer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_dir <= DIR_BWD;
		end else if (grant_rdy && grant_ack) begin
			last_dir <= grant_dir;
		end
	end

endmodule

// ==== design/bidir_fifo.sv ====
/*
 * Bidirectional FIFO, one queue shared by forward and backward streams
 * Expects a single source request per cycle, src_dir names its side
 * Strict FIFO across both directions, the head blocks the other consumer
 * Both consumers read d01_data, only the matching dst rdy qualifies it
 */
`timescale 1ns/1ps
`include "bidir_consts.svh"

module bidir_fifo
	import bidir_pkg::*;
#(
	parameter int DEPTH = `BIDIR_FIFO_DEPTH
) (
	input  logic clk,
	input  logic rst_n,
	input  logic src_rdy,
	input  dir_t src_dir,
	output logic src_ack,
	input  vec_t s0_data,
	input  vec_t s1_data,
	output logic dst0_rdy,
	input  logic dst0_ack,
	output logic dst1_rdy,
	input  logic dst1_ack,
	output vec_t d01_data
);

	tagged_vec_t fifo_in;
	tagged_vec_t fifo_out;
	logic        fifo_out_rdy;
	logic        fifo_out_ack;

	// ==================================================
	// Write side tagging
	// ==================================================
	always_comb begin
		fifo_in.dir  = src_dir;
		fifo_in.data = (src_dir == DIR_FWD) ? s0_data : s1_data;
	end

	// ==================================================
	// Read side steering
	// ==================================================
	always_comb begin
		// Head is offered only to the consumer its tag names
		dst0_rdy = fifo_out_rdy && (fifo_out.dir == DIR_FWD);
		dst1_rdy = fifo_out_rdy && (fifo_out.dir == DIR_BWD);
		// An ack counts only from the consumer that was offered the head
		fifo_out_ack = (dst0_rdy && dst0_ack) || (dst1_rdy && dst1_ack);
		d01_data = fifo_out.data;
	end

	// Shared storage for both directions
	rdyack_fifo #(
		.DEPTH(DEPTH)
	) u_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_rdy  (src_rdy),
		.in_ack  (src_ack),
		.in_data (fifo_in),
		.out_rdy (fifo_out_rdy),
		.out_ack (fifo_out_ack),
		.out_data(fifo_out)
	);

endmodule

// ==== design/bidir_queue_top.sv ====
/*
 * Bidirectional vector queue, top level
 * Producers may request together, the arbiter serialises them
 * Minimum latency from src accept to dst rdy is one cycle
 */
`timescale 1ns/1ps
`include "bidir_consts.svh"

module bidir_queue_top
	import bidir_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	// Forward producer
	input  logic src0_rdy,
	output logic src0_ack,
	input  vec_t src0_data,
	// Backward producer
	input  logic src1_rdy,
	output logic src1_ack,
	input  vec_t src1_data,
	// Consumers, shared data port
	output logic dst0_rdy,
	input  logic dst0_ack,
	output logic dst1_rdy,
	input  logic dst1_ack,
	output vec_t dst_data
);

	// Arbiter to queue request
	logic arb_rdy;
	dir_t arb_dir;
	logic arb_ack;

	src_rr_arbiter u_arb (
		.clk      (clk),
		.rst_n    (rst_n),
		.req0_rdy (src0_rdy),
		.req0_ack (src0_ack),
		.req1_rdy (src1_rdy),
		.req1_ack (src1_ack),
		.grant_rdy(arb_rdy),
		.grant_dir(arb_dir),
		.grant_ack(arb_ack)
	);

	bidir_fifo #(
		.DEPTH(`BIDIR_FIFO_DEPTH)
	) u_bidir (
		.clk     (clk),
		.rst_n   (rst_n),
		.src_rdy (arb_rdy),
		.src_dir (arb_dir),
		.src_ack (arb_ack),
		.s0_data (src0_data),
		.s1_data (src1_data),
		.dst0_rdy(dst0_rdy),
		.dst0_ack(dst0_ack),
		.dst1_rdy(dst1_rdy),
		.dst1_ack(dst1_ack),
		.d01_data(dst_data)
	);

endmodule

// ==== testbench/tb_bidir_queue_top.sv ====
/*
 * Testbench for the bidirectional vector queue
 * Concurrent assertions check order, routing, back-pressure, fairness and latency
 * Needs a simulator with concurrent assertion and $sampled support
 * Random data assumes a vector of at most 32 bits
 */
`timescale 1ns/1ps
`include "bidir_consts.svh"

module tb_bidir_queue_top
	import bidir_pkg::*;
;

	logic clk;
	logic rst_n;
	logic src0_rdy;
	logic src0_ack;
	vec_t src0_data;
	logic src1_rdy;
	logic src1_ack;
	vec_t src1_data;
	logic dst0_rdy;
	logic dst0_ack;
	logic dst1_rdy;
	logic dst1_ack;
	vec_t dst_data;

	// Reference model with mirrors updated on the clock edge
	tagged_vec_t q[$];
	tagged_vec_t m_head = '0;
	int          m_count = 0;
	dir_t        last_dir = DIR_BWD;
	int          acc_count = 0;
	int          cycle = 0;
	// Producer mode 0 idle, 1 random, 2 always; consumer mode 0 idle, 1 random, 2 always
	int          prod_mode = 0;
	int          cons_mode = 0;

	logic exp_rdy0;
	logic exp_rdy1;
	logic dst_xfer;

	assign exp_rdy0 = (m_count != 0) && (m_head.dir == DIR_FWD);
	assign exp_rdy1 = (m_count != 0) && (m_head.dir == DIR_BWD);
	assign dst_xfer = (dst0_rdy && dst0_ack) || (dst1_rdy && dst1_ack);

	bidir_queue_top uut (.*);

	// ==================================================
	// Failure reporting
	// ==================================================
	task automatic abort_run();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic mismatch_error(input string sig, input logic [63:0] exp,
			input logic [63:0] act);
		$display("[ERROR] %0t ns: %s expected %0h got %0h", $time, sig, exp, act);
		abort_run();
	endtask

	task automatic text_error(input string what);
		$display("[ERROR] %0t ns: %s", $time, what);
		abort_run();
	endtask

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Tests take roughly 530 cycles and the limit is over twice that
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= 1200) begin
			text_error("timeout, the run did not finish within 1200 cycles");
		end
	end

	// ==================================================
	// Model update and stimulus
	// ==================================================
	initial begin : model_and_drive
		logic en0;
		logic en1;
		void'($urandom(83));
		forever begin
			@(posedge clk);
			if (!rst_n) begin
				q.delete();
				last_dir <= DIR_BWD;
			end else begin
				// Head leaves before the new entry joins the tail
				if (dst_xfer && q.size() > 0) begin
					void'(q.pop_front());
				end
				if (src0_rdy && src0_ack) begin
					q.push_back('{dir: DIR_FWD, data: src0_data});
					last_dir  <= DIR_FWD;
					acc_count <= acc_count + 1;
				end
				if (src1_rdy && src1_ack) begin
					q.push_back('{dir: DIR_BWD, data: src1_data});
					last_dir  <= DIR_BWD;
					acc_count <= acc_count + 1;
				end
			end
			m_count <= q.size();
			if (q.size() > 0) begin
				m_head <= q[0];
			end
			// Producers hold rdy and data until acked
			if (!src0_rdy || src0_ack) begin
				src0_rdy  <= (prod_mode == 2) || (prod_mode == 1 && $urandom % 2 == 1);
				src0_data <= vec_t'($urandom);
			end
			if (!src1_rdy || src1_ack) begin
				src1_rdy  <= (prod_mode == 2) || (prod_mode == 1 && $urandom % 2 == 1);
				src1_data <= vec_t'($urandom);
			end
			// Consumers ack only where the model says the head will be offered
			en0 = (cons_mode == 2) || (cons_mode == 1 && $urandom % 2 == 1);
			en1 = (cons_mode == 2) || (cons_mode == 1 && $urandom % 2 == 1);
			if (rst_n && q.size() > 0) begin
				dst0_ack <= en0 && (q[0].dir == DIR_FWD);
				dst1_ack <= en1 && (q[0].dir == DIR_BWD);
			end else begin
				dst0_ack <= 1'b0;
				dst1_ack <= 1'b0;
			end
		end
	end

	// ==================================================
	// Assertions
	// ==================================================
	a_rst_rdy: assert property (@(posedge clk) $rose(rst_n) |-> (!dst0_rdy && !dst1_rdy))
		else text_error("a dst rdy is high right after reset");
	a_head0: assert property (@(posedge clk) disable iff (!rst_n) dst0_rdy == exp_rdy0)
		else mismatch_error("dst0_rdy", $sampled(exp_rdy0), $sampled(dst0_rdy));
	a_head1: assert property (@(posedge clk) disable iff (!rst_n) dst1_rdy == exp_rdy1)
		else mismatch_error("dst1_rdy", $sampled(exp_rdy1), $sampled(dst1_rdy));
	// Routing follows from the rdy checks and the payload must be the model head
	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		dst_xfer |-> dst_data == m_head.data)
		else mismatch_error("dst_data", $sampled(m_head.data), $sampled(dst_data));
	a_cap: assert property (@(posedge clk) disable iff (!rst_n) m_count <= `BIDIR_FIFO_DEPTH)
		else mismatch_error("queue occupancy", `BIDIR_FIFO_DEPTH, $sampled(m_count));
	a_full: assert property (@(posedge clk) disable iff (!rst_n)
		(m_count == `BIDIR_FIFO_DEPTH && !dst_xfer) |-> (!src0_ack && !src1_ack))
		else text_error("a src ack went high while the queue was full");
	a_accept: assert property (@(posedge clk) disable iff (!rst_n)
		(m_count < `BIDIR_FIFO_DEPTH && (src0_rdy || src1_rdy)) |-> (src0_ack || src1_ack))
		else text_error("a request was not accepted although the queue had room");
	a_fair: assert property (@(posedge clk) disable iff (!rst_n)
		(src0_rdy && src1_rdy && (src0_ack || src1_ack)) |-> src0_ack == (last_dir == DIR_BWD))
		else mismatch_error("src0_ack", $sampled(last_dir == DIR_BWD), $sampled(src0_ack));
	a_ack0: assert property (@(posedge clk) disable iff (!rst_n) src0_ack |-> src0_rdy)
		else text_error("src0_ack is high without src0_rdy");
	a_ack1: assert property (@(posedge clk) disable iff (!rst_n) src1_ack |-> src1_rdy)
		else text_error("src1_ack is high without src1_rdy");
	a_one: assert property (@(posedge clk) disable iff (!rst_n) !(src0_ack && src1_ack))
		else text_error("both src acks are high in the same cycle");
	a_lat0: assert property (@(posedge clk) disable iff (!rst_n)
		(m_count == 0 && src0_rdy && src0_ack) |=> dst0_rdy)
		else mismatch_error("dst0_rdy", 1, $sampled(dst0_rdy));
	a_lat1: assert property (@(posedge clk) disable iff (!rst_n)
		(m_count == 0 && src1_rdy && src1_ack) |=> dst1_rdy)
		else mismatch_error("dst1_rdy", 1, $sampled(dst1_rdy));

	// ==================================================
	// Test phases
	// ==================================================
	initial begin
		rst_n = 1'b0;
		src0_rdy = 1'b0;
		src0_data = '0;
		src1_rdy = 1'b0;
		src1_data = '0;
		dst0_ack = 1'b0;
		dst1_ack = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// Directed fill with both producers on and consumers idle
		@(posedge clk);
		prod_mode <= 2;
		cons_mode <= 0;
		repeat (12) @(posedge clk);
		a_filled: assert (acc_count == `BIDIR_FIFO_DEPTH)
			else mismatch_error("accepted vectors", `BIDIR_FIFO_DEPTH, acc_count);
		// Contested phase with producers always requesting
		cons_mode <= 1;
		repeat (100) @(posedge clk);
		// Random traffic
		prod_mode <= 1;
		repeat (400) @(posedge clk);
		// Drain until the DUT offers nothing and no producer waits
		prod_mode <= 0;
		cons_mode <= 2;
		@(posedge clk);
		while (dst0_rdy || dst1_rdy || src0_rdy || src1_rdy) begin
			@(posedge clk);
		end
		// An empty DUT must leave nothing behind in the model
		a_drained: assert (m_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			mismatch_error("queue occupancy", 0, m_count);
		end
	end

endmodule

// ==== bidir_queue.f ====
+incdir+design
design/bidir_pkg.sv
design/rdyack_fifo.sv
design/src_rr_arbiter.sv
design/bidir_fifo.sv
design/bidir_queue_top.sv
testbench/tb_bidir_queue_top.sv

// ==== Bender.yml ====
package:
  name: bidir_queue

sources:
  # Synthesizable design, compile order matters
  - include_dirs:
      - design
    files:
      - design/bidir_pkg.sv
      - design/rdyack_fifo.sv
      - design/src_rr_arbiter.sv
      - design/bidir_fifo.sv
      - design/bidir_queue_top.sv

  # Testbench, top module tb_bidir_queue_top
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_bidir_queue_top.sv
